//--- project.f
logic/mips_pkg.sv
logic/ctl_if.sv
logic/rtype_decoder.sv
logic/regimm_decoder.sv
logic/special2_decoder.sv
logic/main_decoder.sv
logic/decode_unit.sv
dv/decode_unit_properties.sv
dv/decode_unit_tb.sv

//--- Makefile
TOP = decode_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ns -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -f project.f \
		--top-module $(TOP) -o sim
	./obj_dir/sim > sim.log 2>&1; cat sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/decode_unit_tb.sv
`timescale 1ns/1ns

module decode_unit_tb;
    // one stimulus row and the control word expected back for it.
    typedef struct packed {
        logic                            valid;
        logic [5:0]                      op;
        logic [5:0]                      sel; // funct, or rt in the low bits.
        logic [mips_pkg::PC_SRC_W-1:0]   pc_src;
        logic [mips_pkg::REG_SRC_W-1:0]  reg_src;
        logic [mips_pkg::DEST_REG_W-1:0] dest_reg;
        logic [mips_pkg::ALU_W-1:0]      alu_op;
        logic [mips_pkg::FLAG_W-1:0]     flag_sel;
        logic [mips_pkg::IMM_SRC_W-1:0]  imm_src;
        logic                            write_reg;
        logic                            read_mem;
        logic [mips_pkg::MEM_READ_W-1:0] read_mode;
        logic                            write_mem;
        logic                            likely;
        logic [mips_pkg::EXC_CHK_W-1:0]  exc_chk;
    } row_t;

    logic                             clk;
    logic                             rst;
    logic                             instr_valid;
    logic [31:0]                      instruction;
    logic                             ctl_valid;
    logic [mips_pkg::PC_SRC_W-1:0]    pc_src;
    logic [mips_pkg::REG_SRC_W-1:0]   reg_src;
    logic [mips_pkg::DEST_REG_W-1:0]  dest_reg;
    logic [mips_pkg::ALU_W-1:0]       alu_op;
    logic [mips_pkg::FLAG_W-1:0]      flag_sel;
    logic [mips_pkg::IMM_SRC_W-1:0]   imm_src;
    logic                             write_reg;
    logic                             read_mem;
    logic [mips_pkg::MEM_READ_W-1:0]  read_mode;
    logic                             write_mem;
    logic [mips_pkg::MEM_WRITE_W-1:0] write_mode;
    logic                             likely;
    logic [mips_pkg::EXC_CHK_W-1:0]   exc_chk;

    row_t        rows[$];
    row_t        pending[$];
    logic        table_ready = 1'b0;
    logic [31:0] lfsr = 32'h48c9_1e73;

    decode_unit decode_unit_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_sel(input string name, input logic [mips_pkg::ALU_W-1:0] got,
                             input logic [mips_pkg::ALU_W-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %0t: %s is %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %0t: %s is %0b, expected %0b", $time, name, got, exp));
        end
    endtask

    task automatic check_exc(input logic [mips_pkg::EXC_CHK_W-1:0] got,
                             input logic [mips_pkg::EXC_CHK_W-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %0t: exc_chk is %0d, expected %0d", $time, got, exp));
        end
    endtask

    // galois lfsr, one step per bit taken.
    function automatic logic [31:0] random_word();
        logic        b;
        logic [31:0] acc;
        acc = 32'h0;
        for (int n = 0; n < 32; n++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ 32'h8020_0003;
            end
            acc = {acc[30:0], b};
        end
        return acc;
    endfunction

    task automatic drive_row(input row_t r);
        mips_pkg::instr_u w;
        w = random_word(); // fields not used by decode stay random.
        w.r.opcode = r.op;
        if (r.op == mips_pkg::OP_REGIMM) begin
            w.i.rt = r.sel[4:0];
        end else if (r.op == mips_pkg::OP_RTYPE || r.op == mips_pkg::OP_SPECIAL2) begin
            w.r.funct = r.sel;
        end
        instruction = w;
        instr_valid = r.valid;
    endtask

    task automatic check_row(input row_t e);
        check_bit("ctl_valid", ctl_valid, e.valid);
        check_bit("write_reg", write_reg, e.write_reg & e.valid);
        check_bit("write_mem", write_mem, e.write_mem & e.valid);
        if (e.valid) begin
            check_sel("pc_src", 4'(pc_src), 4'(e.pc_src));
            check_sel("reg_src", 4'(reg_src), 4'(e.reg_src));
            check_sel("dest_reg", 4'(dest_reg), 4'(e.dest_reg));
            check_sel("alu_op", alu_op, e.alu_op);
            check_sel("flag_sel", 4'(flag_sel), 4'(e.flag_sel));
            check_sel("imm_src", 4'(imm_src), 4'(e.imm_src));
            check_bit("read_mem", read_mem, e.read_mem);
            check_sel("read_mode", 4'(read_mode), 4'(e.read_mode));
            check_sel("write_mode", 4'(write_mode), 4'(mips_pkg::MEM_WRITE_WORD));
            check_bit("likely", likely, e.likely);
            check_exc(exc_chk, e.exc_chk);
        end
    endtask

    initial begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instruction = 32'h0;

        // valid, op, sel, pc, rsrc, dest, alu, flag, imm, wr, rdm, rmode, wm, lk, exc.
        rows.push_back(row_t'{1, 6'h00, 6'h20, 0, 0, 0, 1, 0, 0, 1, 0, 2, 0, 0, 1}); // add.
        rows.push_back(row_t'{1, 6'h00, 6'h22, 0, 0, 0, 2, 0, 0, 1, 0, 2, 0, 0, 1}); // sub.
        rows.push_back(row_t'{1, 6'h00, 6'h03, 0, 0, 0, 9, 0, 0, 1, 0, 2, 0, 0, 0}); // sra.
        rows.push_back(row_t'{1, 6'h00, 6'h2a, 0, 3, 0, 0, 4, 0, 1, 0, 2, 0, 0, 0}); // slt.
        rows.push_back(row_t'{1, 6'h00, 6'h2b, 0, 3, 0, 0, 6, 0, 1, 0, 2, 0, 0, 0}); // sltu.
        rows.push_back(row_t'{1, 6'h00, 6'h08, 2, 0, 0, 0, 0, 0, 0, 0, 2, 0, 0, 0}); // jr.
        rows.push_back(row_t'{1, 6'h00, 6'h09, 2, 2, 0, 0, 0, 0, 1, 0, 2, 0, 0, 0}); // jalr.
        rows.push_back(row_t'{1, 6'h00, 6'h0c, 0, 0, 0, 0, 0, 0, 0, 0, 2, 0, 0, 3}); // syscall.
        rows.push_back(row_t'{1, 6'h00, 6'h0d, 0, 0, 0, 0, 0, 0, 0, 0, 2, 0, 0, 3}); // break.
        rows.push_back(row_t'{1, 6'h00, 6'h3f, 0, 0, 0, 0, 0, 0, 0, 0, 2, 0, 0, 2});
        rows.push_back(row_t'{1, 6'h01, 6'h00, 3, 0, 0, 0, 4, 0, 0, 0, 2, 0, 0, 0}); // bltz.
        rows.push_back(row_t'{1, 6'h01, 6'h01, 3, 0, 0, 0, 5, 0, 0, 0, 2, 0, 0, 0}); // bgez.
        rows.push_back(row_t'{1, 6'h01, 6'h10, 3, 2, 2, 0, 4, 0, 1, 0, 2, 0, 0, 0}); // bltzal.
        rows.push_back(row_t'{1, 6'h01, 6'h11, 3, 2, 2, 0, 5, 0, 1, 0, 2, 0, 0, 0}); // bgezal.
        rows.push_back(row_t'{1, 6'h01, 6'h05, 0, 0, 0, 0, 0, 0, 0, 0, 2, 0, 0, 2});
        rows.push_back(row_t'{1, 6'h1c, 6'h02, 0, 0, 0, 10, 0, 0, 1, 0, 2, 0, 0, 0}); // mul.
        rows.push_back(row_t'{1, 6'h1c, 6'h20, 0, 0, 0, 11, 0, 0, 1, 0, 2, 0, 0, 0}); // clz.
        rows.push_back(row_t'{1, 6'h1c, 6'h21, 0, 0, 0, 12, 0, 0, 1, 0, 2, 0, 0, 0}); // clo.
        rows.push_back(row_t'{1, 6'h1c, 6'h3f, 0, 0, 0, 0, 0, 0, 0, 0, 2, 0, 0, 2});
        rows.push_back(row_t'{1, 6'h02, 6'h00, 1, 0, 1, 0, 0, 0, 0, 0, 2, 0, 0, 0}); // j.
        rows.push_back(row_t'{1, 6'h03, 6'h00, 1, 2, 2, 0, 0, 0, 1, 0, 2, 0, 0, 0}); // jal.
        rows.push_back(row_t'{1, 6'h04, 6'h00, 3, 0, 1, 0, 0, 0, 0, 0, 2, 0, 0, 0}); // beq.
        rows.push_back(row_t'{1, 6'h05, 6'h00, 3, 0, 1, 0, 1, 0, 0, 0, 2, 0, 0, 0});
        rows.push_back(row_t'{1, 6'h06, 6'h00, 3, 0, 1, 0, 2, 0, 0, 0, 2, 0, 0, 0});
        rows.push_back(row_t'{1, 6'h07, 6'h00, 3, 0, 1, 0, 3, 0, 0, 0, 2, 0, 0, 0});
        rows.push_back(row_t'{1, 6'h14, 6'h00, 3, 0, 1, 0, 0, 0, 0, 0, 2, 0, 1, 0}); // beql.
        rows.push_back(row_t'{1, 6'h15, 6'h00, 3, 0, 1, 0, 1, 0, 0, 0, 2, 0, 1, 0});
        rows.push_back(row_t'{1, 6'h16, 6'h00, 3, 0, 1, 0, 2, 0, 0, 0, 2, 0, 1, 0});
        rows.push_back(row_t'{1, 6'h17, 6'h00, 3, 0, 1, 0, 3, 0, 0, 0, 2, 0, 1, 0});
        rows.push_back(row_t'{1, 6'h08, 6'h00, 0, 0, 1, 1, 0, 1, 1, 0, 2, 0, 0, 1}); // addi.
        rows.push_back(row_t'{1, 6'h09, 6'h00, 0, 0, 1, 1, 0, 1, 1, 0, 2, 0, 0, 0}); // addiu.
        rows.push_back(row_t'{1, 6'h0a, 6'h00, 0, 3, 1, 0, 4, 1, 1, 0, 2, 0, 0, 0}); // slti.
        rows.push_back(row_t'{1, 6'h0b, 6'h00, 0, 3, 1, 0, 6, 1, 1, 0, 2, 0, 0, 0}); // sltiu.
        rows.push_back(row_t'{1, 6'h0c, 6'h00, 0, 0, 1, 3, 0, 2, 1, 0, 2, 0, 0, 0}); // andi.
        rows.push_back(row_t'{1, 6'h0d, 6'h00, 0, 0, 1, 4, 0, 2, 1, 0, 2, 0, 0, 0}); // ori.
        rows.push_back(row_t'{1, 6'h0e, 6'h00, 0, 0, 1, 5, 0, 2, 1, 0, 2, 0, 0, 0}); // xori.
        rows.push_back(row_t'{1, 6'h0f, 6'h00, 0, 0, 1, 1, 0, 3, 1, 0, 2, 0, 0, 0}); // lui.
        rows.push_back(row_t'{1, 6'h20, 6'h00, 0, 1, 1, 1, 0, 1, 1, 1, 0, 0, 0, 0}); // lb.
        rows.push_back(row_t'{1, 6'h21, 6'h00, 0, 1, 1, 1, 0, 1, 1, 1, 1, 0, 0, 0}); // lh.
        rows.push_back(row_t'{1, 6'h23, 6'h00, 0, 1, 1, 1, 0, 1, 1, 1, 2, 0, 0, 0}); // lw.
        rows.push_back(row_t'{1, 6'h2b, 6'h00, 0, 0, 1, 1, 0, 1, 0, 0, 2, 1, 0, 0}); // sw.
        rows.push_back(row_t'{1, 6'h3f, 6'h00, 0, 0, 1, 0, 0, 0, 0, 0, 2, 0, 0, 2});
        rows.push_back(row_t'{0, 6'h2b, 6'h00, 0, 0, 1, 1, 0, 1, 0, 0, 2, 1, 0, 0}); // bubble.
        rows.push_back(row_t'{0, 6'h08, 6'h00, 0, 0, 1, 1, 0, 1, 1, 0, 2, 0, 0, 1});
        table_ready = 1'b1;

        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        check_bit("ctl_valid", ctl_valid, 1'b0); // still empty from reset.
        check_bit("write_reg", write_reg, 1'b0);
        check_bit("write_mem", write_mem, 1'b0);
        check_bit("read_mem", read_mem, 1'b0);

        foreach (rows[n]) begin
            drive_row(rows[n]);
            pending.push_back(rows[n]);
            @(posedge clk);
            #2;
            check_row(pending.pop_front());
        end
        instr_valid = 1'b0;

        $display("Finished with no errors");
        $finish;
    end

    // watchdog sized from the table length.
    initial begin
        int unsigned limit_ns;
        wait (table_ready);
        limit_ns = (rows.size() * 2 + 20) * 20;
        #(limit_ns);
        fail_run("timeout: the decode test did not finish in time");
    end
endmodule

//--- dv/decode_unit_properties.sv
`timescale 1ns/1ns

module decode_unit_properties (
    input logic clk,
    input logic rst,
    input logic instr_valid,
    input logic ctl_valid,
    input logic write_reg,
    input logic write_mem
);
    // stage comes out of reset empty.
    reset_empty: assert property (@(posedge clk) rst |=> !ctl_valid)
        else $error("ctl_valid is high in the cycle after reset");

    writes_need_valid: assert property (@(posedge clk) disable iff (rst)
        (write_reg || write_mem) |-> ctl_valid)
        else $error("a write enable is high while ctl_valid is low");

    valid_delay: assert property (@(posedge clk) disable iff (rst)
        ctl_valid == ($past(instr_valid) && !$past(rst)))
        else $error("ctl_valid does not follow instr_valid by one cycle");
endmodule

bind decode_unit decode_unit_properties decode_unit_properties_inst (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .ctl_valid   (ctl_valid),
    .write_reg   (write_reg),
    .write_mem   (write_mem)
);

//--- logic/decode_unit.sv
`timescale 1ns/1ns

module decode_unit (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             instr_valid,
    input  logic [31:0]                      instruction,
    output logic                             ctl_valid,
    output logic [mips_pkg::PC_SRC_W-1:0]    pc_src,
    output logic [mips_pkg::REG_SRC_W-1:0]   reg_src,
    output logic [mips_pkg::DEST_REG_W-1:0]  dest_reg,
    output logic [mips_pkg::ALU_W-1:0]       alu_op,
    output logic [mips_pkg::FLAG_W-1:0]      flag_sel,
    output logic [mips_pkg::IMM_SRC_W-1:0]   imm_src,
    output logic                             write_reg,
    output logic                             read_mem,
    output logic [mips_pkg::MEM_READ_W-1:0]  read_mode,
    output logic                             write_mem,
    output logic [mips_pkg::MEM_WRITE_W-1:0] write_mode,
    output logic                             likely,
    output logic [mips_pkg::EXC_CHK_W-1:0]   exc_chk
);
    mips_pkg::instr_u instr;

    ctl_if rtype_bus ();
    ctl_if regimm_bus ();
    ctl_if special2_bus ();
    ctl_if main_bus ();

    assign instr = instruction;

    rtype_decoder rtype_dec (.instruction(instr), .ctl(rtype_bus.source));
    regimm_decoder regimm_dec (.instruction(instr), .ctl(regimm_bus.source));
    special2_decoder special2_dec (.instruction(instr), .ctl(special2_bus.source));

    main_decoder main_dec (
        .instruction  (instr),
        .rtype_ctl    (rtype_bus.sink),
        .regimm_ctl   (regimm_bus.sink),
        .special2_ctl (special2_bus.sink),
        .ctl          (main_bus.source)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            ctl_valid <= 1'b0;
            write_reg <= 1'b0;
            write_mem <= 1'b0;
            read_mem  <= 1'b0;
        end else begin
            ctl_valid <= instr_valid;
            write_reg <= instr_valid & main_bus.write_reg; // no writes from a bubble.
            write_mem <= instr_valid & main_bus.write_mem;
            read_mem  <= main_bus.read_mem;
        end
    end

    // payload side of the register.
    always_ff @(posedge clk) begin
        pc_src     <= main_bus.pc_src;
        reg_src    <= main_bus.reg_src;
        dest_reg   <= main_bus.dest_reg;
        alu_op     <= main_bus.alu_op;
        flag_sel   <= main_bus.flag_sel;
        imm_src    <= main_bus.imm_src;
        read_mode  <= main_bus.read_mode;
        write_mode <= main_bus.write_mode;
        likely     <= main_bus.likely;
        exc_chk    <= main_bus.exc_chk;
    end
endmodule

//--- logic/main_decoder.sv
`timescale 1ns/1ns

module main_decoder (
    input  mips_pkg::instr_u instruction,
    ctl_if.sink              rtype_ctl,
    ctl_if.sink              regimm_ctl,
    ctl_if.sink              special2_ctl,
    ctl_if.source            ctl
);
    logic [mips_pkg::CTL_W-1:0] sub_word;
    logic [5:0]                 op;

    assign op = instruction.j.opcode;

    assign sub_word = (op == mips_pkg::OP_REGIMM)   ? regimm_ctl.word :
                      (op == mips_pkg::OP_SPECIAL2) ? special2_ctl.word : rtype_ctl.word;

    always_comb begin
        ctl.pc_src     = mips_pkg::PC_SRC_SEQ;
        ctl.reg_src    = mips_pkg::REG_SRC_ALU;
        ctl.dest_reg   = mips_pkg::DEST_REG_RT;
        ctl.alu_op     = mips_pkg::ALU_NCARE;
        ctl.flag_sel   = mips_pkg::FLAG_EQ;
        ctl.imm_src    = mips_pkg::IMM_SRC_NONE;
        ctl.write_reg  = 1'b0;
        ctl.read_mem   = 1'b0;
        ctl.read_mode  = mips_pkg::MEM_READ_WORD;
        ctl.write_mem  = 1'b0;
        ctl.write_mode = mips_pkg::MEM_WRITE_WORD;
        ctl.likely     = 1'b0;
        ctl.exc_chk    = mips_pkg::EXC_CHK_NONE;

        case (op)
            mips_pkg::OP_RTYPE, mips_pkg::OP_REGIMM, mips_pkg::OP_SPECIAL2: begin
                {ctl.pc_src, ctl.reg_src, ctl.dest_reg, ctl.alu_op, ctl.flag_sel, ctl.imm_src,
                 ctl.write_reg, ctl.read_mem, ctl.read_mode, ctl.write_mem, ctl.write_mode,
                 ctl.likely, ctl.exc_chk} = sub_word;
            end
            mips_pkg::OP_J, mips_pkg::OP_JAL: begin
                ctl.pc_src = mips_pkg::PC_SRC_JUMP;
                if (op == mips_pkg::OP_JAL) begin
                    ctl.write_reg = 1'b1;
                    ctl.reg_src   = mips_pkg::REG_SRC_PCADD8;
                    ctl.dest_reg  = mips_pkg::DEST_REG_R31;
                end
            end
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE, mips_pkg::OP_BLEZ, mips_pkg::OP_BGTZ,
            mips_pkg::OP_BEQL, mips_pkg::OP_BNEL, mips_pkg::OP_BLEZL, mips_pkg::OP_BGTZL: begin
                ctl.pc_src = mips_pkg::PC_SRC_BRANCH;
                ctl.likely = op[4]; // the L forms sit at 0x14..0x17.
                case (op[1:0])
                    2'd0:    ctl.flag_sel = mips_pkg::FLAG_EQ;
                    2'd1:    ctl.flag_sel = mips_pkg::FLAG_NE;
                    2'd2:    ctl.flag_sel = mips_pkg::FLAG_LE;
                    default: ctl.flag_sel = mips_pkg::FLAG_GT;
                endcase
            end
            mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU: begin
                ctl.imm_src   = mips_pkg::IMM_SRC_SIGN;
                ctl.alu_op    = mips_pkg::ALU_ADD;
                ctl.write_reg = 1'b1;
                if (op == mips_pkg::OP_ADDI) begin
                    ctl.exc_chk = mips_pkg::EXC_CHK_OVERFLOW;
                end
            end
            mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU: begin
                ctl.imm_src   = mips_pkg::IMM_SRC_SIGN;
                ctl.write_reg = 1'b1;
                ctl.reg_src   = mips_pkg::REG_SRC_FLAG;
                ctl.flag_sel  = (op == mips_pkg::OP_SLTIU) ? mips_pkg::FLAG_LTU : mips_pkg::FLAG_LT;
            end
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI: begin
                ctl.imm_src   = mips_pkg::IMM_SRC_ZERO;
                ctl.write_reg = 1'b1;
                ctl.alu_op    = (op == mips_pkg::OP_ANDI) ? mips_pkg::ALU_AND :
                                (op == mips_pkg::OP_ORI)  ? mips_pkg::ALU_OR : mips_pkg::ALU_XOR;
            end
            mips_pkg::OP_LUI: begin
                ctl.imm_src   = mips_pkg::IMM_SRC_UPPER;
                ctl.alu_op    = mips_pkg::ALU_ADD; // upper imm plus $0.
                ctl.write_reg = 1'b1;
            end
            mips_pkg::OP_LB, mips_pkg::OP_LH, mips_pkg::OP_LW: begin
                ctl.imm_src   = mips_pkg::IMM_SRC_SIGN;
                ctl.alu_op    = mips_pkg::ALU_ADD;
                ctl.read_mem  = 1'b1;
                ctl.write_reg = 1'b1;
                ctl.reg_src   = mips_pkg::REG_SRC_MEM;
                ctl.read_mode = (op == mips_pkg::OP_LB) ? mips_pkg::MEM_READ_BYTE :
                                (op == mips_pkg::OP_LH) ? mips_pkg::MEM_READ_HALF :
                                mips_pkg::MEM_READ_WORD;
            end
            mips_pkg::OP_SW: begin
                ctl.imm_src    = mips_pkg::IMM_SRC_SIGN;
                ctl.alu_op     = mips_pkg::ALU_ADD;
                ctl.write_mem  = 1'b1;
                ctl.write_mode = mips_pkg::MEM_WRITE_WORD;
            end
            default: ctl.exc_chk = mips_pkg::EXC_CHK_RESERVED;
        endcase
    end
endmodule

//--- logic/special2_decoder.sv
`timescale 1ns/1ns

module special2_decoder (
    input  mips_pkg::instr_u instruction,
    ctl_if.source            ctl
);
    always_comb begin
        ctl.pc_src     = mips_pkg::PC_SRC_SEQ;
        ctl.reg_src    = mips_pkg::REG_SRC_ALU;
        ctl.dest_reg   = mips_pkg::DEST_REG_RD;
        ctl.alu_op     = mips_pkg::ALU_NCARE;
        ctl.flag_sel   = mips_pkg::FLAG_EQ;
        ctl.imm_src    = mips_pkg::IMM_SRC_NONE;
        ctl.write_reg  = 1'b0;
        ctl.read_mem   = 1'b0;
        ctl.read_mode  = mips_pkg::MEM_READ_WORD;
        ctl.write_mem  = 1'b0;
        ctl.write_mode = mips_pkg::MEM_WRITE_WORD;
        ctl.likely     = 1'b0;
        ctl.exc_chk    = mips_pkg::EXC_CHK_NONE;

        case (instruction.r.funct)
            mips_pkg::FN_MUL: ctl.alu_op = mips_pkg::ALU_MUL;
            mips_pkg::FN_CLZ: ctl.alu_op = mips_pkg::ALU_CLZ;
            mips_pkg::FN_CLO: ctl.alu_op = mips_pkg::ALU_CLO;
            default:          ctl.exc_chk = mips_pkg::EXC_CHK_RESERVED;
        endcase

        // every valid special2 op writes rd.
        ctl.write_reg = (ctl.exc_chk == mips_pkg::EXC_CHK_NONE);
    end
endmodule

//--- logic/regimm_decoder.sv
`timescale 1ns/1ns

module regimm_decoder (
    input  mips_pkg::instr_u instruction,
    ctl_if.source            ctl
);
    always_comb begin
        ctl.pc_src     = mips_pkg::PC_SRC_SEQ;
        ctl.reg_src    = mips_pkg::REG_SRC_ALU;
        ctl.dest_reg   = mips_pkg::DEST_REG_RD;
        ctl.alu_op     = mips_pkg::ALU_NCARE;
        ctl.flag_sel   = mips_pkg::FLAG_EQ;
        ctl.imm_src    = mips_pkg::IMM_SRC_NONE;
        ctl.write_reg  = 1'b0;
        ctl.read_mem   = 1'b0;
        ctl.read_mode  = mips_pkg::MEM_READ_WORD;
        ctl.write_mem  = 1'b0;
        ctl.write_mode = mips_pkg::MEM_WRITE_WORD;
        ctl.likely     = 1'b0;
        ctl.exc_chk    = mips_pkg::EXC_CHK_NONE;

        case (instruction.i.rt)
            mips_pkg::RT_BLTZ, mips_pkg::RT_BGEZ,
            mips_pkg::RT_BLTZAL, mips_pkg::RT_BGEZAL: begin
                ctl.pc_src   = mips_pkg::PC_SRC_BRANCH;
                // bit 0 of rt picks ge over lt.
                ctl.flag_sel = instruction.i.rt[0] ? mips_pkg::FLAG_GE : mips_pkg::FLAG_LT;
                if (instruction.i.rt[4]) begin
                    ctl.write_reg = 1'b1;
                    ctl.reg_src   = mips_pkg::REG_SRC_PCADD8;
                    ctl.dest_reg  = mips_pkg::DEST_REG_R31;
                end
            end
            default: ctl.exc_chk = mips_pkg::EXC_CHK_RESERVED;
        endcase
    end
endmodule

//--- logic/rtype_decoder.sv
`timescale 1ns/1ns

module rtype_decoder (
    input  mips_pkg::instr_u instruction,
    ctl_if.source            ctl
);
    logic [mips_pkg::ALU_W-1:0] alu_sel;

    always_comb begin
        alu_sel        = mips_pkg::ALU_NCARE;
        ctl.pc_src     = mips_pkg::PC_SRC_SEQ;
        ctl.reg_src    = mips_pkg::REG_SRC_ALU;
        ctl.dest_reg   = mips_pkg::DEST_REG_RD;
        ctl.flag_sel   = mips_pkg::FLAG_EQ;
        ctl.imm_src    = mips_pkg::IMM_SRC_NONE;
        ctl.write_reg  = 1'b0;
        ctl.read_mem   = 1'b0;
        ctl.read_mode  = mips_pkg::MEM_READ_WORD;
        ctl.write_mem  = 1'b0;
        ctl.write_mode = mips_pkg::MEM_WRITE_WORD;
        ctl.likely     = 1'b0;
        ctl.exc_chk    = mips_pkg::EXC_CHK_NONE;

        case (instruction.r.funct)
            mips_pkg::FN_ADD: begin
                alu_sel     = mips_pkg::ALU_ADD;
                ctl.exc_chk = mips_pkg::EXC_CHK_OVERFLOW;
            end
            mips_pkg::FN_SUB: begin
                alu_sel     = mips_pkg::ALU_SUB;
                ctl.exc_chk = mips_pkg::EXC_CHK_OVERFLOW;
            end
            mips_pkg::FN_ADDU: alu_sel = mips_pkg::ALU_ADD;
            mips_pkg::FN_SUBU: alu_sel = mips_pkg::ALU_SUB;
            mips_pkg::FN_AND:  alu_sel = mips_pkg::ALU_AND;
            mips_pkg::FN_OR:   alu_sel = mips_pkg::ALU_OR;
            mips_pkg::FN_XOR:  alu_sel = mips_pkg::ALU_XOR;
            mips_pkg::FN_NOR:  alu_sel = mips_pkg::ALU_NOR;
            mips_pkg::FN_SLL:  alu_sel = mips_pkg::ALU_SLL; // amount from shamt.
            mips_pkg::FN_SRL:  alu_sel = mips_pkg::ALU_SRL;
            mips_pkg::FN_SRA:  alu_sel = mips_pkg::ALU_SRA;
            mips_pkg::FN_SLT, mips_pkg::FN_SLTU: begin
                ctl.write_reg = 1'b1;
                ctl.reg_src   = mips_pkg::REG_SRC_FLAG;
                ctl.flag_sel  = (instruction.r.funct == mips_pkg::FN_SLTU) ?
                                mips_pkg::FLAG_LTU : mips_pkg::FLAG_LT;
            end
            mips_pkg::FN_JR:   ctl.pc_src = mips_pkg::PC_SRC_REG;
            mips_pkg::FN_JALR: begin
                ctl.pc_src    = mips_pkg::PC_SRC_REG;
                ctl.write_reg = 1'b1;
                ctl.reg_src   = mips_pkg::REG_SRC_PCADD8; // link into rd.
            end
            mips_pkg::FN_SYSCALL, mips_pkg::FN_BREAK: ctl.exc_chk = mips_pkg::EXC_CHK_TRAP;
            default: ctl.exc_chk = mips_pkg::EXC_CHK_RESERVED;
        endcase

        ctl.alu_op = alu_sel;
        if (alu_sel != mips_pkg::ALU_NCARE) begin
            ctl.write_reg = 1'b1; // all alu ops land in rd.
        end
    end
endmodule

//--- logic/ctl_if.sv
`timescale 1ns/1ns

interface ctl_if;
    logic [mips_pkg::PC_SRC_W-1:0]    pc_src;
    logic [mips_pkg::REG_SRC_W-1:0]   reg_src;
    logic [mips_pkg::DEST_REG_W-1:0]  dest_reg;
    logic [mips_pkg::ALU_W-1:0]       alu_op;
    logic [mips_pkg::FLAG_W-1:0]      flag_sel;
    logic [mips_pkg::IMM_SRC_W-1:0]   imm_src;
    logic                             write_reg;
    logic                             read_mem;
    logic [mips_pkg::MEM_READ_W-1:0]  read_mode;
    logic                             write_mem;
    logic [mips_pkg::MEM_WRITE_W-1:0] write_mode;
    logic                             likely;
    logic [mips_pkg::EXC_CHK_W-1:0]   exc_chk;
    logic [mips_pkg::CTL_W-1:0]       word;

    // whole bundle flattened for forwarding.
    assign word = {pc_src, reg_src, dest_reg, alu_op, flag_sel, imm_src, write_reg,
                   read_mem, read_mode, write_mem, write_mode, likely, exc_chk};

    modport source (output pc_src, reg_src, dest_reg, alu_op, flag_sel, imm_src, write_reg,
                    read_mem, read_mode, write_mem, write_mode, likely, exc_chk);
    modport sink (input pc_src, reg_src, dest_reg, alu_op, flag_sel, imm_src, write_reg,
                  read_mem, read_mode, write_mem, write_mode, likely, exc_chk, word);
endinterface

//--- logic/mips_pkg.sv
package mips_pkg;

    // instruction field widths.
    localparam int OPCODE_W = 6;
    localparam int REG_W    = 5;
    localparam int FUNCT_W  = 6;
    localparam int IMM_W    = 16;
    localparam int TARGET_W = 26;

    // one word, three readings.
    typedef union packed {
        struct packed {
            logic [OPCODE_W-1:0] opcode;
            logic [REG_W-1:0]    rs;
            logic [REG_W-1:0]    rt;
            logic [REG_W-1:0]    rd;
            logic [REG_W-1:0]    shamt;
            logic [FUNCT_W-1:0]  funct;
        } r;
        struct packed {
            logic [OPCODE_W-1:0] opcode;
            logic [REG_W-1:0]    rs;
            logic [REG_W-1:0]    rt;
            logic [IMM_W-1:0]    imm16;
        } i;
        struct packed {
            logic [OPCODE_W-1:0] opcode;
            logic [TARGET_W-1:0] target26;
        } j;
    } instr_u;

    localparam logic [5:0] OP_RTYPE = 6'h00, OP_REGIMM = 6'h01, OP_SPECIAL2 = 6'h1c;
    localparam logic [5:0] OP_J = 6'h02, OP_JAL = 6'h03;
    localparam logic [5:0] OP_BEQ = 6'h04, OP_BNE = 6'h05, OP_BLEZ = 6'h06, OP_BGTZ = 6'h07;
    localparam logic [5:0] OP_BEQL = 6'h14, OP_BNEL = 6'h15;
    localparam logic [5:0] OP_BLEZL = 6'h16, OP_BGTZL = 6'h17;
    localparam logic [5:0] OP_ADDI = 6'h08, OP_ADDIU = 6'h09, OP_SLTI = 6'h0a, OP_SLTIU = 6'h0b;
    localparam logic [5:0] OP_ANDI = 6'h0c, OP_ORI = 6'h0d, OP_XORI = 6'h0e, OP_LUI = 6'h0f;
    localparam logic [5:0] OP_LB = 6'h20, OP_LH = 6'h21, OP_LW = 6'h23, OP_SW = 6'h2b;

    localparam logic [5:0] FN_SLL = 6'h00, FN_SRL = 6'h02, FN_SRA = 6'h03;
    localparam logic [5:0] FN_JR = 6'h08, FN_JALR = 6'h09, FN_SYSCALL = 6'h0c, FN_BREAK = 6'h0d;
    localparam logic [5:0] FN_ADD = 6'h20, FN_ADDU = 6'h21, FN_SUB = 6'h22, FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND = 6'h24, FN_OR = 6'h25, FN_XOR = 6'h26, FN_NOR = 6'h27;
    localparam logic [5:0] FN_SLT = 6'h2a, FN_SLTU = 6'h2b;
    localparam logic [5:0] FN_MUL = 6'h02, FN_CLZ = 6'h20, FN_CLO = 6'h21; // special2.

    localparam logic [4:0] RT_BLTZ = 5'h00, RT_BGEZ = 5'h01;
    localparam logic [4:0] RT_BLTZAL = 5'h10, RT_BGEZAL = 5'h11;

    localparam int PC_SRC_W = 2, REG_SRC_W = 2, DEST_REG_W = 2, ALU_W = 4;
    localparam int FLAG_W = 3, IMM_SRC_W = 2, MEM_READ_W = 2, MEM_WRITE_W = 1, EXC_CHK_W = 2;
    // selectors plus the four single-bit enables.
    localparam int CTL_W = PC_SRC_W + REG_SRC_W + DEST_REG_W + ALU_W + FLAG_W + IMM_SRC_W
                         + MEM_READ_W + MEM_WRITE_W + EXC_CHK_W + 4;

    localparam logic [1:0] PC_SRC_SEQ = 2'd0, PC_SRC_JUMP = 2'd1;
    localparam logic [1:0] PC_SRC_REG = 2'd2, PC_SRC_BRANCH = 2'd3;
    localparam logic [1:0] REG_SRC_ALU = 2'd0, REG_SRC_MEM = 2'd1;
    localparam logic [1:0] REG_SRC_PCADD8 = 2'd2, REG_SRC_FLAG = 2'd3;
    localparam logic [1:0] DEST_REG_RD = 2'd0, DEST_REG_RT = 2'd1, DEST_REG_R31 = 2'd2;
    localparam logic [3:0] ALU_NCARE = 4'd0, ALU_ADD = 4'd1, ALU_SUB = 4'd2, ALU_AND = 4'd3;
    localparam logic [3:0] ALU_OR = 4'd4, ALU_XOR = 4'd5, ALU_NOR = 4'd6, ALU_SLL = 4'd7;
    localparam logic [3:0] ALU_SRL = 4'd8, ALU_SRA = 4'd9, ALU_MUL = 4'd10;
    localparam logic [3:0] ALU_CLZ = 4'd11, ALU_CLO = 4'd12;
    localparam logic [2:0] FLAG_EQ = 3'd0, FLAG_NE = 3'd1, FLAG_LE = 3'd2, FLAG_GT = 3'd3;
    localparam logic [2:0] FLAG_LT = 3'd4, FLAG_GE = 3'd5, FLAG_LTU = 3'd6;
    localparam logic [1:0] IMM_SRC_NONE = 2'd0, IMM_SRC_SIGN = 2'd1;
    localparam logic [1:0] IMM_SRC_ZERO = 2'd2, IMM_SRC_UPPER = 2'd3;
    localparam logic [1:0] MEM_READ_BYTE = 2'd0, MEM_READ_HALF = 2'd1, MEM_READ_WORD = 2'd2;
    localparam logic [0:0] MEM_WRITE_WORD = 1'b0;
    localparam logic [1:0] EXC_CHK_NONE = 2'd0, EXC_CHK_OVERFLOW = 2'd1;
    localparam logic [1:0] EXC_CHK_RESERVED = 2'd2, EXC_CHK_TRAP = 2'd3;

endpackage
